// File: i2c_cfg_pkg.sv
`default_nettype none

package i2c_cfg_pkg;

    localparam int REG_W        = 8;
    localparam int CNT_W        = 16;
    localparam int DFSR_FIELD_W = 6;

    typedef logic [2:0] reg_addr_t;    // address bits [4:2]

    localparam reg_addr_t ADDR_ADR   = 3'd0;
    localparam reg_addr_t ADDR_FDR   = 3'd1;
    localparam reg_addr_t ADDR_CR    = 3'd2;
    localparam reg_addr_t ADDR_DFSRR = 3'd5;

    localparam logic [REG_W-1:0] RST_ADR     = 8'h00;
    localparam logic [REG_W-1:0] RST_FDR     = 8'h00;
    localparam logic [REG_W-1:0] RST_CR      = 8'h00;
    localparam logic [REG_W-1:0] RST_DFSRR   = 8'h10;
    localparam logic [REG_W-1:0] RST_RD_DATA = 8'hFF;

    localparam logic [CNT_W-1:0] RST_PRESCALE = 16'd384;
    localparam logic [CNT_W-1:0] RST_DFSR_CNT = 16'd24;    // 384 / 16

    // scl divider per fdr[5:0]
    localparam logic [CNT_W-1:0] PRESCALE_TBL [64] = '{
        384,   416,   480,   576,   640,   704,   832,   1024,
        1152,  1280,  1536,  1920,  2304,  2560,  3072,  3840,
        4608,  5120,  6144,  7680,  9216,  10240, 12288, 15360,
        18432, 20480, 24576, 30720, 36864, 40960, 49152, 61440,
        256,   288,   320,   352,   384,   448,   512,   576,
        640,   768,   896,   1024,  1280,  1536,  1792,  2048,
        2560,  3072,  3584,  4096,  5120,  6144,  7168,  8192,
        10240, 12288, 14336, 16384, 20480, 24576, 28672, 32768
    };

    function automatic logic [CNT_W-1:0] prescale_lookup(input logic [REG_W-1:0] fdr);
        return PRESCALE_TBL[fdr[5:0]];    // top two bits don't care
    endfunction

    typedef struct packed {
        logic                    valid;
        logic [CNT_W-1:0]        rem;    // partial remainder
        logic [CNT_W-1:0]        quo;
        logic [CNT_W-1:0]        dvd;
        logic [DFSR_FIELD_W-1:0] dsr;
    } div_item_t;

    typedef struct packed {
        logic [REG_W-1:0] fdr;
        logic [REG_W-1:0] dfsrr;
        logic             launch;
    } cfg_wr_t;

endpackage

`default_nettype wire

// File: i2c_cfg_regs.sv
`default_nettype none
`timescale 1ns/10ps

module i2c_cfg_regs (
    input  wire                            i_sysclk,
    input  wire                            i_reset_n,
    input  wire                            i_wr_ena,
    input  wire [4:0]                      i_wr_addr,
    input  wire [i2c_cfg_pkg::REG_W-1:0]   i_wr_data,
    input  wire                            i_rd_ena,
    input  wire [4:0]                      i_rd_addr,
    output logic [i2c_cfg_pkg::REG_W-1:0]  o_rd_data,
    output i2c_cfg_pkg::cfg_wr_t           o_cfg
);
    import i2c_cfg_pkg::*;

    logic [REG_W-1:0] adr_r;
    logic [REG_W-1:0] fdr_r;
    logic [REG_W-1:0] cr_r;
    logic [REG_W-1:0] dfsrr_r;
    logic             launch_pend;    // write to fdr/dfsrr seen last edge
    reg_addr_t        wr_sel;
    reg_addr_t        rd_sel;
    logic             wr_cnt_hit;

    assign wr_sel = i_wr_addr[4:2];
    assign rd_sel = i_rd_addr[4:2];

    // any write that changes the prescale or the divisor
    assign wr_cnt_hit = i_wr_ena && ((wr_sel == ADDR_FDR) || (wr_sel == ADDR_DFSRR));

    always_ff @(posedge i_sysclk or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            adr_r   <= RST_ADR;
            fdr_r   <= RST_FDR;
            cr_r    <= RST_CR;
            dfsrr_r <= RST_DFSRR;
        end
        else if (i_wr_ena)
        begin
            case (wr_sel)
                ADDR_ADR   : adr_r   <= i_wr_data;
                ADDR_FDR   : fdr_r   <= i_wr_data;
                ADDR_CR    : cr_r    <= i_wr_data;
                ADDR_DFSRR : dfsrr_r <= i_wr_data;
                default    : ;    // unmapped, dropped
            endcase
        end
    end

    // read data holds between strobes
    always_ff @(posedge i_sysclk or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            o_rd_data <= RST_RD_DATA;
        end
        else if (i_rd_ena)
        begin
            case (rd_sel)
                ADDR_ADR   : o_rd_data <= adr_r;
                ADDR_FDR   : o_rd_data <= fdr_r;
                ADDR_CR    : o_rd_data <= cr_r;
                ADDR_DFSRR : o_rd_data <= dfsrr_r;
                default    : o_rd_data <= '0;
            endcase
        end
    end

    // launch lines up with the new fdr/dfsrr in the outgoing bundle
    always_ff @(posedge i_sysclk or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            launch_pend <= 1'b0;
            o_cfg       <= '{fdr: RST_FDR, dfsrr: RST_DFSRR, launch: 1'b0};
        end
        else
        begin
            launch_pend <= wr_cnt_hit;
            o_cfg       <= '{fdr: fdr_r, dfsrr: dfsrr_r, launch: launch_pend};
        end
    end

endmodule

`default_nettype wire

// File: fdr_prescale_feed.sv
`default_nettype none
`timescale 1ns/10ps

module fdr_prescale_feed (
    input  wire                            i_sysclk,
    input  wire                            i_reset_n,
    input  wire i2c_cfg_pkg::cfg_wr_t      i_cfg,
    output logic [i2c_cfg_pkg::CNT_W-1:0]  o_prescale,
    output i2c_cfg_pkg::div_item_t         o_item
);
    import i2c_cfg_pkg::*;

    logic [CNT_W-1:0]        prescale_nxt;
    logic [CNT_W-1:0]        prescale_r;
    logic [DFSR_FIELD_W-1:0] dsr_r;
    logic                    valid_r;

    assign prescale_nxt = prescale_lookup(i_cfg.fdr);

    always_ff @(posedge i_sysclk or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            prescale_r <= RST_PRESCALE;
            valid_r    <= 1'b0;
        end
        else
        begin
            prescale_r <= prescale_nxt;
            valid_r    <= i_cfg.launch;    // one item per launch
        end
    end

    // divisor field, only looked at while valid_r is set
    always_ff @(posedge i_sysclk)
    begin
        dsr_r <= i_cfg.dfsrr[DFSR_FIELD_W-1:0];
    end

    assign o_prescale = prescale_r;

    // fresh division: nothing shifted in yet
    assign o_item = '{
        valid: valid_r,
        rem:   '0,
        quo:   '0,
        dvd:   prescale_r,
        dsr:   dsr_r
    };

endmodule

`default_nettype wire

// File: dfsr_div_stage.sv
`default_nettype none
`timescale 1ns/10ps

module dfsr_div_stage #(
    parameter int DIV_WIDTH   = 16,
    parameter int STAGE_INDEX = 0
) (
    input  wire                              i_sysclk,
    input  wire                              i_reset_n,
    input  wire i2c_cfg_pkg::div_item_t      i_item,
    output i2c_cfg_pkg::div_item_t           o_item
);
    import i2c_cfg_pkg::*;

    // msb first, stage 0 takes the top dividend bit
    localparam int BIT_POS = DIV_WIDTH - 1 - STAGE_INDEX;

    logic [CNT_W-1:0]        rem_sh;
    logic [CNT_W-1:0]        dsr_ext;
    logic                    q_bit;
    logic                    valid_r;
    logic [CNT_W-1:0]        rem_r;
    logic [CNT_W-1:0]        quo_r;
    logic [CNT_W-1:0]        dvd_r;
    logic [DFSR_FIELD_W-1:0] dsr_r;

    assign rem_sh  = {i_item.rem[CNT_W-2:0], i_item.dvd[BIT_POS]};
    assign dsr_ext = CNT_W'(i_item.dsr);
    assign q_bit   = (rem_sh >= dsr_ext);    // dsr 0 always sets the bit

    always_ff @(posedge i_sysclk or negedge i_reset_n)
    begin
        if (!i_reset_n)
            valid_r <= 1'b0;
        else
            valid_r <= i_item.valid;
    end

    always_ff @(posedge i_sysclk)
    begin
        rem_r <= q_bit ? (rem_sh - dsr_ext) : rem_sh;
        quo_r <= {i_item.quo[CNT_W-2:0], q_bit};
        dvd_r <= i_item.dvd;
        dsr_r <= i_item.dsr;
    end

    assign o_item = '{valid: valid_r, rem: rem_r, quo: quo_r, dvd: dvd_r, dsr: dsr_r};

endmodule

`default_nettype wire

// File: dfsr_div_drain.sv
`default_nettype none
`timescale 1ns/10ps

module dfsr_div_drain #(
    parameter int DIV_WIDTH = 16
) (
    input  wire                            i_sysclk,
    input  wire                            i_reset_n,
    input  wire i2c_cfg_pkg::div_item_t    i_item,
    output logic [i2c_cfg_pkg::CNT_W-1:0]  o_dfsr_cnt,
    output logic                           o_cnt_update
);
    import i2c_cfg_pkg::*;

    always_ff @(posedge i_sysclk or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            o_dfsr_cnt   <= RST_DFSR_CNT;
            o_cnt_update <= 1'b0;
        end
        else
        begin
            o_cnt_update <= i_item.valid;    // single-cycle pulse per item
            if (i_item.valid)
                o_dfsr_cnt <= CNT_W'(i_item.quo[DIV_WIDTH-1:0]);
        end
    end

endmodule

`default_nettype wire

// File: i2c_cfg_top.sv
`default_nettype none
`timescale 1ns/10ps

module i2c_cfg_top #(
    parameter int DIV_WIDTH = 16
) (
    input  wire                            i_sysclk,
    input  wire                            i_reset_n,
    input  wire                            i_wr_ena,
    input  wire [4:0]                      i_wr_addr,
    input  wire [i2c_cfg_pkg::REG_W-1:0]   i_wr_data,
    input  wire                            i_rd_ena,
    input  wire [4:0]                      i_rd_addr,
    output logic [i2c_cfg_pkg::REG_W-1:0]  o_rd_data,
    output logic [i2c_cfg_pkg::CNT_W-1:0]  o_prescale,
    output logic [i2c_cfg_pkg::CNT_W-1:0]  o_dfsr_cnt,
    output logic                           o_cnt_update
);
    import i2c_cfg_pkg::*;

    cfg_wr_t   cfg;
    div_item_t stage_item [DIV_WIDTH+1];    // [0] from feed, [DIV_WIDTH] into drain

    i2c_cfg_regs u_regs (
        .i_sysclk  (i_sysclk),
        .i_reset_n (i_reset_n),
        .i_wr_ena  (i_wr_ena),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_rd_ena  (i_rd_ena),
        .i_rd_addr (i_rd_addr),
        .o_rd_data (o_rd_data),
        .o_cfg     (cfg)
    );

    fdr_prescale_feed u_feed (
        .i_sysclk   (i_sysclk),
        .i_reset_n  (i_reset_n),
        .i_cfg      (cfg),
        .o_prescale (o_prescale),
        .o_item     (stage_item[0])
    );

    genvar k;
    generate
        for (k = 0; k < DIV_WIDTH; k++)
        begin : g_stage
            dfsr_div_stage #(
                .DIV_WIDTH   (DIV_WIDTH),
                .STAGE_INDEX (k)
            ) u_stage (
                .i_sysclk  (i_sysclk),
                .i_reset_n (i_reset_n),
                .i_item    (stage_item[k]),
                .o_item    (stage_item[k+1])
            );
        end
    endgenerate

    dfsr_div_drain #(
        .DIV_WIDTH (DIV_WIDTH)
    ) u_drain (
        .i_sysclk     (i_sysclk),
        .i_reset_n    (i_reset_n),
        .i_item       (stage_item[DIV_WIDTH]),
        .o_dfsr_cnt   (o_dfsr_cnt),
        .o_cnt_update (o_cnt_update)
    );

endmodule

`default_nettype wire

// File: i2c_cfg_props.sv
`default_nettype none
`timescale 1ns/10ps

module i2c_cfg_props #(
    parameter int DIV_WIDTH = 16
) (
    input wire                         i_sysclk,
    input wire                         i_reset_n,
    input wire i2c_cfg_pkg::cfg_wr_t   i_cfg,
    input wire i2c_cfg_pkg::div_item_t i_drain_item,
    input wire                         i_cnt_update
);
    logic launch;
    logic drain_valid;

    assign launch      = i_cfg.launch;
    assign drain_valid = i_drain_item.valid;

    // every count update traces back to its own launch
    a_update_has_launch : assert property (
        @(posedge i_sysclk) disable iff (!i_reset_n)
        i_cnt_update |-> $past(launch, DIV_WIDTH+2)
    ) else $error("count update without a matching launch");

    a_quiet_in_reset : assert property (
        @(posedge i_sysclk) !i_reset_n |-> !i_cnt_update
    ) else $error("count update high during reset");

    a_launch_to_drain : assert property (
        @(posedge i_sysclk) disable iff (!i_reset_n)
        launch |-> ##(DIV_WIDTH+1) drain_valid
    ) else $error("launched item did not reach the drain on time");

endmodule

bind i2c_cfg_top i2c_cfg_props #(.DIV_WIDTH(DIV_WIDTH)) u_props (
    .i_sysclk     (i_sysclk),
    .i_reset_n    (i_reset_n),
    .i_cfg        (cfg),
    .i_drain_item (stage_item[DIV_WIDTH]),
    .i_cnt_update (o_cnt_update)
);

`default_nettype wire

// File: tb_i2c_cfg.sv
`default_nettype none
`timescale 1ns/10ps

module tb_i2c_cfg;
    import i2c_cfg_pkg::*;

    localparam int DIV_WIDTH = 16;
    localparam int LATENCY   = DIV_WIDTH + 3;    // write edge to count update
    localparam int TBL_LEN   = 64;
    localparam int MAX_OPS   = 40;
    localparam int N_RANDOM  = 8;
    localparam int DRIVE_DLY = 5;

    logic             i_sysclk;
    logic             i_reset_n;
    logic             i_wr_ena;
    logic [4:0]       i_wr_addr;
    logic [REG_W-1:0] i_wr_data;
    logic             i_rd_ena;
    logic [4:0]       i_rd_addr;
    logic [REG_W-1:0] o_rd_data;
    logic [CNT_W-1:0] o_prescale;
    logic [CNT_W-1:0] o_dfsr_cnt;
    logic             o_cnt_update;

    // prescale table first, then six words per operation
    logic [15:0]      gold [TBL_LEN + 6*MAX_OPS];
    int               n_ops;
    int               cycle_cnt = 0;
    int               write_cycles [$];    // edges of writes that launch a division
    int               launches = 0;
    int               pulses = 0;
    int               seed = 87;
    bit               loaded = 1'b0;
    logic [REG_W-1:0] cur_fdr;
    logic [REG_W-1:0] cur_dfsrr;

    i2c_cfg_top #(
        .DIV_WIDTH (DIV_WIDTH)
    ) uut (
        .i_sysclk     (i_sysclk),
        .i_reset_n    (i_reset_n),
        .i_wr_ena     (i_wr_ena),
        .i_wr_addr    (i_wr_addr),
        .i_wr_data    (i_wr_data),
        .i_rd_ena     (i_rd_ena),
        .i_rd_addr    (i_rd_addr),
        .o_rd_data    (o_rd_data),
        .o_prescale   (o_prescale),
        .o_dfsr_cnt   (o_dfsr_cnt),
        .o_cnt_update (o_cnt_update)
    );

    initial
    begin
        i_sysclk = 1'b0;
        forever #50 i_sysclk = ~i_sysclk;
    end

    always @(posedge i_sysclk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (o_cnt_update)
            pulses <= pulses + 1;
    end

    task automatic abort_run(input string msg);
        $display("Verification failed");
        $fatal(1, "%s", msg);
    endtask

    task automatic next_cycle();
        @(posedge i_sysclk);
        #DRIVE_DLY;
    endtask

    task automatic check_rd_data(input logic [REG_W-1:0] got, input logic [REG_W-1:0] exp);
        if (got !== exp)
        begin
            $display("Error at %0t: o_rd_data is 0x%02h, expected 0x%02h", $time, got, exp);
            abort_run("read data mismatch");
        end
    endtask

    task automatic check_cnt(input string what, input logic [CNT_W-1:0] got,
                             input logic [CNT_W-1:0] exp);
        if (got !== exp)
        begin
            $display("Error at %0t: %s is 0x%04h, expected 0x%04h", $time, what, got, exp);
            abort_run("count or prescale mismatch");
        end
    endtask

    // floor of prescale over the six divisor bits, zero divisor saturates
    function automatic logic [CNT_W-1:0] expected_count(input logic [CNT_W-1:0] pre,
                                                        input logic [REG_W-1:0] dfsrr);
        logic [CNT_W-1:0] dsr;
        dsr = {10'd0, dfsrr[5:0]};
        if (dsr == '0)
            return '1;
        return pre / dsr;
    endfunction

    task automatic write_reg(input logic [4:0] addr, input logic [REG_W-1:0] data);
        i_wr_ena  = 1'b1;
        i_wr_addr = addr;
        i_wr_data = data;
        next_cycle();
        i_wr_ena = 1'b0;
        if (addr[4:2] == ADDR_FDR || addr[4:2] == ADDR_DFSRR)
        begin
            write_cycles.push_back(cycle_cnt);
            launches++;
        end
        if (addr[4:2] == ADDR_FDR)
            cur_fdr = data;
        if (addr[4:2] == ADDR_DFSRR)
            cur_dfsrr = data;
    endtask

    task automatic write_and_check(input logic [4:0] addr, input logic [REG_W-1:0] data,
                                   input logic [CNT_W-1:0] exp_pre);
        write_reg(addr, data);
        repeat (2) next_cycle();    // regs edge, then feed edge
        check_cnt("o_prescale", o_prescale, exp_pre);
    endtask

    task automatic read_reg(input logic [4:0] addr, input logic [REG_W-1:0] exp);
        i_rd_ena  = 1'b1;
        i_rd_addr = addr;
        next_cycle();
        i_rd_ena = 1'b0;
        check_rd_data(o_rd_data, exp);
    endtask

    task automatic wait_count(input logic [CNT_W-1:0] exp);
        int waited;
        int issued;
        waited = 0;
        do
        begin
            next_cycle();
            waited++;
        end
        while (!o_cnt_update && waited < LATENCY + 4);
        if (!o_cnt_update)
            abort_run("no count update arrived after a launching write");
        else if (write_cycles.size() == 0)
            abort_run("count update arrived without a launching write");
        issued = write_cycles.pop_front();
        if (cycle_cnt - issued != LATENCY)
        begin
            $display("Error at %0t: count update %0d edges after its write, expected %0d",
                     $time, cycle_cnt - issued, LATENCY);
            abort_run("count update latency mismatch");
        end
        check_cnt("o_dfsr_cnt", o_dfsr_cnt, exp);
    endtask

    initial
    begin
        logic [15:0] op;
        logic [31:0] rnd;
        int          base;
        i_reset_n = 1'b0;
        i_wr_ena  = 1'b0;
        i_wr_addr = '0;
        i_wr_data = '0;
        i_rd_ena  = 1'b0;
        i_rd_addr = '0;
        cur_fdr   = 8'h00;
        cur_dfsrr = 8'h10;
        $readmemh("i2c_cfg_golden.txt", gold);
        n_ops = 0;
        while (n_ops < MAX_OPS && gold[TBL_LEN + 6*n_ops] !== 16'h000F)
            n_ops++;
        if (n_ops == MAX_OPS)
            abort_run("golden file missing or without end marker");
        loaded = 1'b1;
        repeat (4) @(posedge i_sysclk);
        #DRIVE_DLY;
        i_reset_n = 1'b1;

        for (int n = 0; n < n_ops; n++)
        begin
            base = TBL_LEN + 6*n;
            op   = gold[base];
            case (op)
                16'h0:
                begin
                    check_cnt("o_prescale", o_prescale, gold[base+3]);
                    check_cnt("o_dfsr_cnt", o_dfsr_cnt, gold[base+4]);
                    check_rd_data(o_rd_data, gold[base+5][7:0]);
                end
                16'h1: write_and_check(gold[base+1][4:0], gold[base+2][7:0], gold[base+3]);
                16'h2: read_reg(gold[base+1][4:0], gold[base+5][7:0]);
                16'h3: wait_count(gold[base+4]);
                16'h4: write_reg(gold[base+1][4:0], gold[base+2][7:0]);
                default: abort_run("unknown operation code in golden file");
            endcase
        end

        // random fdr codes, then a random divisor on top of each
        for (int r = 0; r < N_RANDOM; r++)
        begin
            rnd = $random(seed);
            write_and_check(5'h04, rnd[7:0], gold[rnd[5:0]]);
            wait_count(expected_count(gold[cur_fdr[5:0]], cur_dfsrr));
            rnd = $random(seed);
            write_and_check(5'h14, rnd[7:0], gold[cur_fdr[5:0]]);
            wait_count(expected_count(gold[cur_fdr[5:0]], cur_dfsrr));
        end

        repeat (2) next_cycle();
        if (pulses != launches || write_cycles.size() != 0)
            abort_run("count update pulses do not match the launching writes");
        else
        begin
            $display("Verification passed");
            $finish;
        end
    end

    initial
    begin
        wait (loaded);
        repeat ((n_ops + 2*N_RANDOM) * 25 + 100) @(posedge i_sysclk);
        abort_run("timeout, the run did not finish within its cycle budget");
    end

endmodule

`default_nettype wire

// File: i2c_cfg_golden.txt
// first 64 words: expected prescale per fdr[5:0], hex
// then one line per operation: op addr data prescale count rd_data, hex
// op 0 check outputs, 1 write then check prescale, 2 read, 3 wait for count, 4 write only, F end
0180 01A0 01E0 0240 0280 02C0 0340 0400
0480 0500 0600 0780 0900 0A00 0C00 0F00
1200 1400 1800 1E00 2400 2800 3000 3C00
4800 5000 6000 7800 9000 A000 C000 F000
0100 0120 0140 0160 0180 01C0 0200 0240
0280 0300 0380 0400 0500 0600 0700 0800
0A00 0C00 0E00 1000 1400 1800 1C00 2000
2800 3000 3800 4000 5000 6000 7000 8000
0 00 00 0180 0018 00FF
2 00 00 0000 0000 0000
2 04 00 0000 0000 0000
2 08 00 0000 0000 0000
2 14 00 0000 0000 0010
2 1C 00 0000 0000 0000
1 00 5A 0180 0000 0000
1 08 C3 0180 0000 0000
2 00 00 0000 0000 005A
2 08 00 0000 0000 00C3
1 04 1F F000 0000 0000
3 00 00 0000 0F00 0000
1 14 03 F000 0000 0000
3 00 00 0000 5000 0000
1 04 E0 0100 0000 0000
3 00 00 0000 0055 0000
2 04 00 0000 0000 00E0
1 14 00 0100 0000 0000
3 00 00 0000 FFFF 0000
1 04 40 0180 0000 0000
3 00 00 0000 FFFF 0000
4 14 07 0000 0000 0000
4 04 3F 0000 0000 0000
4 14 D5 0000 0000 0000
3 00 00 0000 0036 0000
3 00 00 0000 1249 0000
3 00 00 0000 0618 0000
0 00 00 8000 0618 00E0
F 00 00 0000 0000 0000

// File: sim.f
i2c_cfg_pkg.sv
i2c_cfg_regs.sv
fdr_prescale_feed.sv
dfsr_div_stage.sv
dfsr_div_drain.sv
i2c_cfg_top.sv
i2c_cfg_props.sv
tb_i2c_cfg.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_i2c_cfg
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
